//--- include/kd_cfg.svh
// KD-tree leaf search configuration, tree shape and patch geometry
`ifndef KD_CFG_SVH
`define KD_CFG_SVH

// Tree shape
`define KD_DEPTH   7                        // Internal levels, root is depth 0
`define KD_NODES   ((1 << `KD_DEPTH) - 1)   // 127 internal nodes
`define KD_LEAVES  (1 << `KD_DEPTH)         // 128 leaves

// Patch geometry
`define KD_COORD_W 11                       // Bits per coordinate
`define KD_DIMS    5                        // Coordinates per patch
`define KD_DIM_W   3                        // Split dimension selector width

`endif

//--- src/kd_pkg.sv
// Shared types for the KD-tree search: coordinates, patches, node words, leaf index
`default_nettype none

`include "kd_cfg.svh"

package kd_pkg;

  // One unsigned coordinate
  typedef logic [`KD_COORD_W-1:0] kd_coord_t;

  // Query patch, coordinate 0 sits in the low bits
  typedef kd_coord_t [`KD_DIMS-1:0] kd_patch_t;

  // Split dimension, only 0 to KD_DIMS-1 are legal
  typedef logic [`KD_DIM_W-1:0] kd_dim_t;

  // Word held by each internal node, 14 bits
  typedef struct packed {
    kd_dim_t   dim;     // Coordinate to compare
    kd_coord_t thresh;  // Split value, equal goes right
  } kd_node_word_t;

  // Leaf index, first decision in the MSB
  typedef logic [`KD_DEPTH-1:0] kd_leaf_t;

endpackage

`default_nettype wire

//--- src/kd_node_loader.sv
// Node write decoder that counts writes in a load phase and one-hot enables the target node
`timescale 1ns/1ps
`default_nettype none

`include "kd_cfg.svh"

module kd_node_loader (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  load_en,   // Level that is high for the whole load phase
  input  wire logic                  node_wr,   // One-cycle write strobe
  output logic      [`KD_NODES-1:0]  node_wen,  // One-hot with bit k for node k
  output logic                       loaded     // Whole tree written
);

  logic [`KD_DEPTH-1:0] wcnt;  // Next node to write that saturates at KD_NODES
  logic                 wr;    // Accepted write this cycle

  // Writes past the last node are dropped
  assign wr = load_en && node_wr && (wcnt != `KD_NODES);

  // Count to one-hot decode, gated by the write itself
  always_comb begin
    for (int i = 0; i < `KD_NODES; i++) begin
      node_wen[i] = wr && (wcnt == i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wcnt   <= '0;
      loaded <= 1'b0;
    end else begin
      if (!load_en) begin
        wcnt <= '0;                     // Every phase restarts at the root
      end else if (wr) begin
        wcnt <= wcnt + 1'b1;
      end
      if (wr && (wcnt == '0))
        loaded <= 1'b0;                 // First write of a new phase
      if (wr && (wcnt == `KD_NODES - 1))
        loaded <= 1'b1;                 // Last node just written
    end
  end

  // At most one node takes the bus word
  a_wen_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(node_wen));

endmodule

`default_nettype wire

//--- src/kd_node.sv
// KD-tree internal node, holds a split word and steers the valid bit left or right
`timescale 1ns/1ps
`default_nettype none

`include "kd_cfg.svh"

module kd_node (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wen,          // Decoded write enable for this node
  input  wire kd_pkg::kd_node_word_t wdata,        // Shared node data bus
  input  wire logic                  valid,        // Patch is at this node
  input  wire kd_pkg::kd_patch_t     patch,
  output logic                       valid_left,   // Coordinate below threshold
  output logic                       valid_right   // Coordinate at or above threshold
);

  import kd_pkg::*;

  kd_node_word_t word_q;     // Stored split
  kd_coord_t     sel_coord;  // Coordinate picked by the split dimension
  logic          go_left;

  always_ff @(posedge clk) begin
    if (!rst_n)
      word_q <= '0;
    else if (wen)
      word_q <= wdata;  // Takes effect on the sampling edge
  end

  assign sel_coord = patch[word_q.dim];

  // Strictly less goes left, ties go right
  assign go_left = (sel_coord < word_q.thresh);

  // Only the node holding the token passes it on
  assign valid_left  = valid && go_left;
  assign valid_right = valid && !go_left;

  // Sender must only load legal split dimensions
  a_dim_legal: assert property (@(posedge clk) disable iff (!rst_n)
    wen |-> (wdata.dim < `KD_DIMS));

endmodule

`default_nettype wire

//--- src/kd_tree_level.sv
// One KD-tree depth, all nodes of the level plus the pipeline register to the next level
`timescale 1ns/1ps
`default_nettype none

module kd_tree_level #(
  parameter int LEVEL = 0  // Depth, root is 0
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic      [2**LEVEL-1:0]    node_wen,   // Write enables of this level's nodes
  input  wire kd_pkg::kd_node_word_t       node_data,
  input  wire logic      [2**LEVEL-1:0]    valid_in,   // Token, one bit per node
  input  wire kd_pkg::kd_patch_t           patch_in,
  output logic           [2**(LEVEL+1)-1:0] valid_out, // Token, one bit per child
  output kd_pkg::kd_patch_t                patch_out
);

  localparam int NODES = 2**LEVEL;

  // Child valids in breadth-first order, node j feeds bits 2j and 2j+1
  logic [2*NODES-1:0] child_valid;

  genvar j;
  generate
    for (j = 0; j < NODES; j++) begin : g_node
      kd_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[j]),
        .wdata       (node_data),
        .valid       (valid_in[j]),
        .patch       (patch_in),
        .valid_left  (child_valid[2*j]),    // Left appends a 0 to the path
        .valid_right (child_valid[2*j+1])   // Right appends a 1
      );
    end
  endgenerate

  // Token register, cleared by reset
  always_ff @(posedge clk) begin
    if (!rst_n)
      valid_out <= '0;
    else
      valid_out <= child_valid;
  end

  // Patch rides along with its token
  always_ff @(posedge clk) begin
    patch_out <= patch_in;
  end

  // A single patch per stage, so the token never splits
  a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(valid_out));

endmodule

`default_nettype wire

//--- src/kd_leaf_encoder.sv
// Leaf encoder, registers the one-hot leaf vector as a binary index with a strobe
`timescale 1ns/1ps
`default_nettype none

`include "kd_cfg.svh"

module kd_leaf_encoder (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [`KD_LEAVES-1:0] leaf_onehot,  // Token after the last level
  output logic                       leaf_valid,
  output kd_pkg::kd_leaf_t           leaf_index
);

  import kd_pkg::*;

  kd_leaf_t idx_d;  // Position of the set bit

  // Bit position equals the left/right path, first decision in the MSB
  always_comb begin
    idx_d = '0;
    for (int i = 0; i < `KD_LEAVES; i++) begin
      if (leaf_onehot[i])
        idx_d = kd_leaf_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      leaf_valid <= 1'b0;
    else
      leaf_valid <= |leaf_onehot;  // Strobe, one cycle per patch
  end

  // Index only meaningful with leaf_valid
  always_ff @(posedge clk) begin
    leaf_index <= idx_d;
  end

  // The tree levels must deliver a single leaf at most
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(leaf_onehot));

endmodule

`default_nettype wire

//--- src/kd_tree_top.sv
// KD-tree leaf search top, node loader, seven comparator levels and leaf encoder
`timescale 1ns/1ps
`default_nettype none

`include "kd_cfg.svh"

module kd_tree_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  load_en,      // Load phase level
  input  wire logic                  node_wr,      // Node word strobe
  input  wire kd_pkg::kd_node_word_t node_data,
  input  wire logic                  patch_valid,  // Query strobe
  input  wire kd_pkg::kd_patch_t     patch_in,
  output logic                       loaded,
  output logic                       leaf_valid,   // 8 registers after patch_valid
  output kd_pkg::kd_leaf_t           leaf_index
);

  import kd_pkg::*;

  wire [`KD_NODES-1:0] node_wen;  // One-hot node write enable, breadth-first

  // Token bits of all depths in one vector, depth L starts at 2^L - 1
  wire [2*`KD_LEAVES-2:0] valid_chain;

  // Patch at the input of each depth
  wire kd_patch_t patch_chain [0:`KD_DEPTH];

  assign valid_chain[0]  = patch_valid;  // Root holds the token on entry
  assign patch_chain[0]  = patch_in;

  kd_node_loader u_loader (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_en  (load_en),
    .node_wr  (node_wr),
    .node_wen (node_wen),
    .loaded   (loaded)
  );

  // Same node numbering slices the enables and the token chain
  genvar lvl;
  generate
    for (lvl = 0; lvl < `KD_DEPTH; lvl++) begin : g_level
      kd_tree_level #(
        .LEVEL (lvl)
      ) u_level (
        .clk       (clk),
        .rst_n     (rst_n),
        .node_wen  (node_wen[(1 << lvl) - 1 +: (1 << lvl)]),
        .node_data (node_data),                                // Broadcast
        .valid_in  (valid_chain[(1 << lvl) - 1 +: (1 << lvl)]),
        .patch_in  (patch_chain[lvl]),
        .valid_out (valid_chain[(2 << lvl) - 1 +: (2 << lvl)]),
        .patch_out (patch_chain[lvl+1])
      );
    end
  endgenerate

  // Last depth's token is the one-hot leaf vector
  kd_leaf_encoder u_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .leaf_onehot (valid_chain[`KD_LEAVES-1 +: `KD_LEAVES]),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

endmodule

`default_nettype wire

//--- testbench/tb_kd_tree.sv
// KD-tree leaf search testbench that loads trees and checks leaves against a software tree walk
`timescale 1ns/1ps
`default_nettype none

`include "kd_cfg.svh"

module tb_kd_tree;

  import kd_pkg::*;

  // Rough test lengths in cycles for reset, idle, load, directed, stream and reload
  localparam int TEST_CYCLES = 3 + 10 + 132 + 5 * 14 + 214 + 250;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          load_en;
  logic          node_wr;
  kd_node_word_t node_data;
  logic          patch_valid;
  kd_patch_t     patch_in;
  logic          loaded;
  logic          leaf_valid;
  kd_leaf_t      leaf_index;

  kd_node_word_t tree [0:`KD_NODES-1];  // Software copy of the node words
  kd_leaf_t      exp_q [$];             // Expected leaves, oldest first
  int            sent_q [$];            // Cycle in which each query was driven
  logic [31:0]   lfsr = 32'hbc9f9c6f;
  int            cyc = 0;
  int            checks = 0;
  int            errors = 0;

  kd_tree_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .node_wr     (node_wr),
    .node_data   (node_data),
    .patch_valid (patch_valid),
    .patch_in    (patch_in),
    .loaded      (loaded),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

  always #4 clk = ~clk;  // 8 ns period

  // Cycle count doubles as the run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cyc);
      $display("Checks failed");
      $finish;
    end
  end

  // Taps 32 22 2 1 with one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic kd_node_word_t random_word();
    kd_node_word_t w;
    w.dim    = kd_dim_t'(rand_bits(`KD_DIM_W) % `KD_DIMS);  // Legal dimensions only
    w.thresh = kd_coord_t'(rand_bits(`KD_COORD_W));
    return w;
  endfunction

  function automatic kd_patch_t random_patch();
    kd_patch_t p;
    for (int d = 0; d < `KD_DIMS; d++)
      p[d] = kd_coord_t'(rand_bits(`KD_COORD_W));
    return p;
  endfunction

  function automatic kd_patch_t fill_patch(input kd_coord_t v);
    kd_patch_t p;
    for (int d = 0; d < `KD_DIMS; d++)
      p[d] = v;
    return p;
  endfunction

  // Walk the copy from the root where less goes left and equal or more goes right
  function automatic kd_leaf_t model_leaf(input kd_patch_t p);
    kd_node_word_t w;
    kd_leaf_t      leaf;
    logic          right;
    int            j;
    leaf = '0;
    j = 0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      w = tree[(1 << lvl) - 1 + j];  // Breadth-first index
      right = !(p[w.dim] < w.thresh);
      leaf = {leaf[`KD_DEPTH-2:0], right};  // First decision ends up in the MSB
      j = 2 * j + int'(right);
    end
    return leaf;
  endfunction

  // Patch that ties with every node on its path whose dimension is still free
  function automatic kd_patch_t tie_path_patch();
    kd_patch_t           p;
    kd_node_word_t       w;
    logic [`KD_DIMS-1:0] fixed;
    int                  j;
    p = '0;
    fixed = '0;
    j = 0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      w = tree[(1 << lvl) - 1 + j];
      if (!fixed[w.dim]) begin
        p[w.dim] = w.thresh;
        fixed[w.dim] = 1'b1;
      end
      j = 2 * j + int'(!(p[w.dim] < w.thresh));
    end
    return p;
  endfunction

  task automatic check_leaf(input string name, input kd_leaf_t got, input kd_leaf_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input int got);
    checks++;
    if (got != 8) begin
      errors++;
      $display("error at %0t ns: leaf_valid latency is %0d, expected 8", $time, got);
    end
  endtask

  // Every result must match the oldest query in flight
  always @(negedge clk) begin
    if (rst_n && leaf_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("leaf_valid went high at %0t ns with no query in flight", $time);
      end else begin
        check_leaf("leaf_index", leaf_index, exp_q.pop_front());
        check_latency(cyc - sent_q.pop_front());
      end
    end
  end

  task automatic drive_write(input kd_node_word_t w);
    load_en   = 1'b1;
    node_wr   = 1'b1;
    node_data = w;
  endtask

  task automatic send_patch(input kd_patch_t p);
    @(negedge clk);
    patch_valid = 1'b1;
    patch_in    = p;
    exp_q.push_back(model_leaf(p));
    sent_q.push_back(cyc);  // Sampled on the next rising edge
  endtask

  // Stop sending and wait for the pipe to empty
  task automatic wait_results();
    int n;
    n = 0;
    @(negedge clk);
    patch_valid = 1'b0;
    while (exp_q.size() != 0 && n < 12) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results never came out by %0t ns", exp_q.size(), $time);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  task automatic idle_after_reset();
    int e0;
    e0 = errors;
    repeat (10) begin
      @(negedge clk);
      check_bit("loaded", loaded, 1'b0);
      check_bit("leaf_valid", leaf_valid, 1'b0);
    end
    report_test("idle after reset", e0);
  endtask

  task automatic load_first_tree();
    int e0;
    e0 = errors;
    for (int k = 0; k < `KD_NODES; k++) begin
      @(negedge clk);
      if (k == `KD_NODES - 1)
        check_bit("loaded", loaded, 1'b0);  // 126 writes so far
      tree[k] = random_word();
      drive_write(tree[k]);
    end
    @(negedge clk);
    node_wr = 1'b0;
    check_bit("loaded", loaded, 1'b1);
    load_en = 1'b0;                         // Phase ends and the count clears
    @(negedge clk);
    drive_write(tree[0]);                   // Lands on the root again with the copy unchanged
    @(negedge clk);
    node_wr = 1'b0;
    load_en = 1'b0;
    check_bit("loaded", loaded, 1'b0);
    report_test("load first tree", e0);
  endtask

  task automatic directed_queries();
    int        e0;
    kd_patch_t p;
    e0 = errors;
    send_patch(fill_patch('0));             // Lowest corner
    wait_results();
    send_patch(fill_patch(11'h7ff));        // Highest corner
    wait_results();
    send_patch(fill_patch(tree[0].thresh)); // Root tie goes right
    wait_results();
    send_patch(tie_path_patch());
    wait_results();
    for (int d = 0; d < `KD_DIMS; d++)
      p[d] = (d % 2 == 1) ? 11'h7ff : 11'h000;
    send_patch(p);
    wait_results();
    report_test("directed queries", e0);
  endtask

  task automatic stream_queries();
    int e0;
    e0 = errors;
    repeat (200)
      send_patch(random_patch());           // One per cycle without gaps
    wait_results();
    report_test("stream queries", e0);
  endtask

  task automatic reload_tree();
    int e0;
    e0 = errors;
    for (int k = 0; k < 40; k++) begin      // Partial phase
      @(negedge clk);
      tree[k] = random_word();
      drive_write(tree[k]);
    end
    @(negedge clk);
    node_wr = 1'b0;
    load_en = 1'b0;                         // Gap restarts at the root
    check_bit("loaded", loaded, 1'b0);
    for (int k = 0; k < `KD_NODES; k++) begin
      @(negedge clk);
      tree[k] = random_word();
      drive_write(tree[k]);
    end
    @(negedge clk);
    node_wr = 1'b0;
    load_en = 1'b0;
    check_bit("loaded", loaded, 1'b1);
    repeat (60)
      send_patch(random_patch());
    wait_results();
    report_test("reload tree", e0);
  endtask

  initial begin
    rst_n       = 1'b0;
    load_en     = 1'b0;
    node_wr     = 1'b0;
    node_data   = '0;
    patch_valid = 1'b0;
    patch_in    = '0;
    repeat (3) @(negedge clk);              // Three rising edges in reset
    rst_n = 1'b1;
    idle_after_reset();
    load_first_tree();
    directed_queries();
    stream_queries();
    reload_tree();
    repeat (10) @(negedge clk);             // Catch late strobes
    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
src/kd_pkg.sv
src/kd_node_loader.sv
src/kd_node.sv
src/kd_tree_level.sv
src/kd_leaf_encoder.sv
src/kd_tree_top.sv
testbench/tb_kd_tree.sv

//--- run.sh
#!/bin/sh
# Build the KD-tree testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_kd_tree \
  && ./obj_dir/Vtb_kd_tree | tee /dev/stderr | grep -q "All checks passed" \
  || { echo "simulation run failed"; exit 1; }

echo "simulation run ok"
exit 0
